/* logic/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and instruction word width
`define DATA_W 16

// Register file has eight entries
`define REG_W 3

// Bubble instruction is opcode 00001 with all other fields zero
`define NOP_INSTR 16'h0800

`endif

/* logic/isa_pkg.sv */
`include "core_settings.svh"

package isa_pkg;

  typedef enum logic [4:0] {
    OP_NOP  = 5'b00001,
    OP_ADDI = 5'b01000,
    OP_SUBI = 5'b01001,
    OP_ANDI = 5'b01010,
    OP_ST   = 5'b10000,
    OP_LD   = 5'b10001,
    OP_ADD  = 5'b11000,
    OP_SUB  = 5'b11001,
    OP_AND  = 5'b11010,
    OP_XOR  = 5'b11011
  } opcodeT;

  typedef logic [`REG_W-1:0] regAddrT;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_AND = 2'b01,
    ALU_XOR = 2'b10
  } aluOpT;

  // Low five bits are imm5 for I-type and carry rd in imm5[4:2] for R-type
  typedef struct packed {
    opcodeT      opcode;
    regAddrT     rs;
    regAddrT     rt;
    logic [4:0]  imm5;
  } instrT;

endpackage

/* logic/pipe_pkg.sv */
`include "core_settings.svh"

package pipe_pkg;

  // The ID/EX bubble relies on instr being the last field
  typedef struct packed {
    logic             regWrite;
    logic             memWrite;
    logic             memEn;
    logic             memToReg;
    logic             invA;
    logic             invB;
    logic             cin;
    logic             aluSrc2;
    isa_pkg::aluOpT   aluOp;
    logic             readingRs;
    logic             readingRt;
    isa_pkg::regAddrT writeReg;
    isa_pkg::instrT   instr;
  } ctrlPayloadT;

  typedef struct packed {
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] opA;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] imm;
  } dataPayloadT;

endpackage

/* logic/decodeUnit.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeUnit (
  input  isa_pkg::instrT     instr,
  output logic               regWrite,
  output logic               memWrite,
  output logic               memEn,
  output logic               memToReg,
  output logic               invA,
  output logic               invB,
  output logic               cin,
  output logic               aluSrc2,
  output isa_pkg::aluOpT     aluOp,
  output isa_pkg::regAddrT   writeReg,
  output isa_pkg::regAddrT   rs,
  output isa_pkg::regAddrT   rt,
  output logic               readingRs,
  output logic               readingRt,
  output logic [`DATA_W-1:0] imm
);
  import isa_pkg::*;

  logic [`DATA_W-1:0] immSext;
  logic [`DATA_W-1:0] immZext;
  logic               useRd;
  logic               zeroExt;

  assign rs = instr.rs;
  assign rt = instr.rt;

  assign immSext = {{(`DATA_W-5){instr.imm5[4]}}, instr.imm5};
  assign immZext = {{(`DATA_W-5){1'b0}}, instr.imm5};
  assign imm     = zeroExt ? immZext : immSext;

  // No destination unless the instruction writes back
  assign writeReg = !regWrite ? '0 : (useRd ? instr.imm5[4:2] : instr.rt);

  always_comb begin
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memEn     = 1'b0;
    memToReg  = 1'b0;
    invA      = 1'b0;
    invB      = 1'b0;
    cin       = 1'b0;
    aluSrc2   = 1'b0;
    aluOp     = ALU_ADD;
    readingRs = 1'b0;
    readingRt = 1'b0;
    useRd     = 1'b0;
    zeroExt   = 1'b0;
    case (instr.opcode)
      OP_ADDI, OP_SUBI, OP_ANDI: begin
        regWrite  = 1'b1;
        aluSrc2   = 1'b1;
        readingRs = 1'b1;
        // Subtract as rs + ~imm + 1
        invB      = (instr.opcode == OP_SUBI);
        cin       = (instr.opcode == OP_SUBI);
        zeroExt   = (instr.opcode == OP_ANDI);
        aluOp     = (instr.opcode == OP_ANDI) ? ALU_AND : ALU_ADD;
      end
      OP_LD: begin
        regWrite  = 1'b1;
        memEn     = 1'b1;
        memToReg  = 1'b1;
        aluSrc2   = 1'b1;
        readingRs = 1'b1;
      end
      OP_ST: begin
        memWrite  = 1'b1;
        memEn     = 1'b1;
        aluSrc2   = 1'b1;
        readingRs = 1'b1;
        readingRt = 1'b1;
      end
      OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
        regWrite  = 1'b1;
        readingRs = 1'b1;
        readingRt = 1'b1;
        useRd     = 1'b1;
        invB      = (instr.opcode == OP_SUB);
        cin       = (instr.opcode == OP_SUB);
        case (instr.opcode)
          OP_AND:  aluOp = ALU_AND;
          OP_XOR:  aluOp = ALU_XOR;
          default: aluOp = ALU_ADD;
        endcase
      end
      // NOP and unknown opcodes keep every level low
      default: ;
    endcase
  end

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
  input  isa_pkg::regAddrT rs,
  input  isa_pkg::regAddrT rt,
  input  logic             readingRs,
  input  logic             readingRt,
  input  logic             exMemToReg,
  input  isa_pkg::regAddrT exWriteReg,
  output logic             stall
);

  logic rsHit;
  logic rtHit;

  // Only sources the decoded instruction really reads can conflict
  assign rsHit = readingRs && (rs == exWriteReg);
  assign rtHit = readingRt && (rt == exWriteReg);

  // Load in ID/EX whose result is not ready for the instruction in decode
  assign stall = exMemToReg && (rsHit || rtHit);

endmodule

/* logic/stageLatch.sv */
`timescale 1ns/1ps

module stageLatch #(
  parameter type     payloadT  = logic,
  parameter payloadT bubbleVal = '0
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    en,
  input  logic    bubble,
  input  payloadT d,
  output payloadT q
);

  // Bubble only takes effect on an enabled cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      q <= '0;
    end else if (en) begin
      q <= bubble ? bubbleVal : d;
    end
  end

endmodule

/* logic/idExLatch.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module idExLatch (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  en,
  input  logic                  stall,
  input  pipe_pkg::ctrlPayloadT ctrlIn,
  input  pipe_pkg::dataPayloadT dataIn,
  output pipe_pkg::ctrlPayloadT ctrlOut,
  output pipe_pkg::dataPayloadT dataOut
);
  import pipe_pkg::*;

  // Bubble control word has all levels low and the NOP encoding in instr
  localparam int CTRL_BITS = $bits(ctrlPayloadT);
  localparam logic [CTRL_BITS-1:0] NOP_BITS =
    {{(CTRL_BITS-`DATA_W){1'b0}}, `NOP_INSTR};

  stageLatch #(
    .payloadT  (ctrlPayloadT),
    .bubbleVal (ctrlPayloadT'(NOP_BITS))
  ) uCtrlLatch (
    .clk    (clk),
    .rstN   (rstN),
    .en     (en),
    .bubble (stall),
    .d      (ctrlIn),
    .q      (ctrlOut)
  );

  // Operands are don't-care in a bubble, so they load as usual
  stageLatch #(
    .payloadT (dataPayloadT)
  ) uDataLatch (
    .clk    (clk),
    .rstN   (rstN),
    .en     (en),
    .bubble (1'b0),
    .d      (dataIn),
    .q      (dataOut)
  );

endmodule

/* logic/executeUnit.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module executeUnit (
  input  pipe_pkg::ctrlPayloadT ctrl,
  input  pipe_pkg::dataPayloadT data,
  output logic [`DATA_W-1:0]    aluResult
);
  import isa_pkg::*;

  logic [`DATA_W-1:0] srcB;
  logic [`DATA_W-1:0] aIn;
  logic [`DATA_W-1:0] bIn;
  logic [`DATA_W-1:0] carryIn;

  // Second operand is the register value or the extended immediate
  assign srcB = ctrl.aluSrc2 ? data.imm : data.opB;

  assign aIn = data.opA ^ {`DATA_W{ctrl.invA}};
  assign bIn = srcB ^ {`DATA_W{ctrl.invB}};

  assign carryIn = {{(`DATA_W-1){1'b0}}, ctrl.cin};

  always_comb begin
    case (ctrl.aluOp)
      ALU_ADD: aluResult = aIn + bIn + carryIn;
      ALU_AND: aluResult = aIn & bIn;
      ALU_XOR: aluResult = aIn ^ bIn;
      default: aluResult = '0;
    endcase
  end

endmodule

/* logic/decodeExecute.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeExecute (
  input  logic               clk,
  input  logic               rstN,
  input  logic               en,
  input  isa_pkg::instrT     instr,
  input  logic [`DATA_W-1:0] pc,
  input  logic [`DATA_W-1:0] opA,
  input  logic [`DATA_W-1:0] opB,
  output logic               stall,
  output logic [`DATA_W-1:0] aluResult,
  output logic               regWrite,
  output logic               memWrite,
  output logic               memEn,
  output logic               memToReg,
  output isa_pkg::regAddrT   writeReg,
  output logic [`DATA_W-1:0] pcOut,
  output logic [`DATA_W-1:0] storeData,
  output logic [`DATA_W-1:0] exInstr
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic               decRegWrite;
  logic               decMemWrite;
  logic               decMemEn;
  logic               decMemToReg;
  logic               decInvA;
  logic               decInvB;
  logic               decCin;
  logic               decAluSrc2;
  aluOpT              decAluOp;
  regAddrT            decWriteReg;
  regAddrT            decRs;
  regAddrT            decRt;
  logic               decReadingRs;
  logic               decReadingRt;
  logic [`DATA_W-1:0] decImm;
  ctrlPayloadT        ctrlIn;
  dataPayloadT        dataIn;
  ctrlPayloadT        exCtrl;
  dataPayloadT        exData;

  decodeUnit uDecode (
    .instr     (instr),
    .regWrite  (decRegWrite),
    .memWrite  (decMemWrite),
    .memEn     (decMemEn),
    .memToReg  (decMemToReg),
    .invA      (decInvA),
    .invB      (decInvB),
    .cin       (decCin),
    .aluSrc2   (decAluSrc2),
    .aluOp     (decAluOp),
    .writeReg  (decWriteReg),
    .rs        (decRs),
    .rt        (decRt),
    .readingRs (decReadingRs),
    .readingRt (decReadingRt),
    .imm       (decImm)
  );

  hazardUnit uHazard (
    .rs         (decRs),
    .rt         (decRt),
    .readingRs  (decReadingRs),
    .readingRt  (decReadingRt),
    .exMemToReg (exCtrl.memToReg),
    .exWriteReg (exCtrl.writeReg),
    .stall      (stall)
  );

  assign ctrlIn = '{
    regWrite:  decRegWrite,
    memWrite:  decMemWrite,
    memEn:     decMemEn,
    memToReg:  decMemToReg,
    invA:      decInvA,
    invB:      decInvB,
    cin:       decCin,
    aluSrc2:   decAluSrc2,
    aluOp:     decAluOp,
    readingRs: decReadingRs,
    readingRt: decReadingRt,
    writeReg:  decWriteReg,
    instr:     instr
  };

  assign dataIn = '{pc: pc, opA: opA, opB: opB, imm: decImm};

  idExLatch uIdEx (
    .clk     (clk),
    .rstN    (rstN),
    .en      (en),
    .stall   (stall),
    .ctrlIn  (ctrlIn),
    .dataIn  (dataIn),
    .ctrlOut (exCtrl),
    .dataOut (exData)
  );

  executeUnit uExecute (
    .ctrl      (exCtrl),
    .data      (exData),
    .aluResult (aluResult)
  );

  assign regWrite  = exCtrl.regWrite;
  assign memWrite  = exCtrl.memWrite;
  assign memEn     = exCtrl.memEn;
  assign memToReg  = exCtrl.memToReg;
  assign writeReg  = exCtrl.writeReg;
  assign exInstr   = exCtrl.instr;
  assign pcOut     = exData.pc;
  // Store data is the rt register value carried through as opB
  assign storeData = exData.opB;

endmodule

/* bench/decodeExecute_asserts.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeExecute_asserts (
  input logic               clk,
  input logic               rstN,
  input logic               en,
  input logic               stall,
  input logic               regWrite,
  input logic               memWrite,
  input logic               memEn,
  input logic               memToReg,
  input isa_pkg::regAddrT   writeReg,
  input logic [`DATA_W-1:0] aluResult,
  input logic [`DATA_W-1:0] pcOut,
  input logic [`DATA_W-1:0] storeData,
  input logic [`DATA_W-1:0] exInstr
);

  // An enabled stall cycle loads a bubble
  bubbleControlsLow: assert property (@(posedge clk)
    rstN && en && stall |=> !memEn && !memWrite && !memToReg && !regWrite)
    else $error("ERROR %0t: memory controls active in the cycle after a stall", $time);

  bubbleIsNop: assert property (@(posedge clk)
    rstN && en && stall |=> exInstr == `NOP_INSTR)
    else $error("ERROR %0t: bubble instruction is not the NOP encoding", $time);

  holdWhileDisabled: assert property (@(posedge clk)
    rstN && !en |=> $stable({regWrite, memWrite, memEn, memToReg, writeReg,
                             aluResult, pcOut, storeData, exInstr}))
    else $error("ERROR %0t: outputs changed while en was low", $time);

endmodule

bind decodeExecute decodeExecute_asserts uAsserts (
  .clk       (clk),
  .rstN      (rstN),
  .en        (en),
  .stall     (stall),
  .regWrite  (regWrite),
  .memWrite  (memWrite),
  .memEn     (memEn),
  .memToReg  (memToReg),
  .writeReg  (writeReg),
  .aluResult (aluResult),
  .pcOut     (pcOut),
  .storeData (storeData),
  .exInstr   (exInstr)
);

/* bench/decodeExecute_tb.sv */
`timescale 1ns/1ps
`include "core_settings.svh"

module decodeExecute_tb;
  import isa_pkg::*;

  localparam int RANDOM_COUNT = 300;
  // Up to six cycles per random instruction, plus directed and reset cycles
  localparam int MAX_CYCLES = 2000;

  typedef struct packed {
    logic               regWrite;
    logic               memWrite;
    logic               memEn;
    logic               memToReg;
    logic [`REG_W-1:0]  writeReg;
    logic               aluValid;
    logic [`DATA_W-1:0] aluResult;
    logic [`DATA_W-1:0] instr;
    logic [`DATA_W-1:0] pc;
    logic [`DATA_W-1:0] storeData;
  } expectT;

  logic               clk;
  logic               rstN;
  logic               en;
  logic [`DATA_W-1:0] instr;
  logic [`DATA_W-1:0] pc;
  logic [`DATA_W-1:0] opA;
  logic [`DATA_W-1:0] opB;
  logic               stall;
  logic [`DATA_W-1:0] aluResult;
  logic               regWrite;
  logic               memWrite;
  logic               memEn;
  logic               memToReg;
  logic [`REG_W-1:0]  writeReg;
  logic [`DATA_W-1:0] pcOut;
  logic [`DATA_W-1:0] storeData;
  logic [`DATA_W-1:0] exInstr;

  expectT             modelOut;
  integer             seed;
  int                 errorCount;
  int                 checkCount;
  int                 stallCount;
  int                 cycleCount;
  logic [`DATA_W-1:0] pcNext;

  decodeExecute u_dut (
    .clk       (clk),
    .rstN      (rstN),
    .en        (en),
    .instr     (instr),
    .pc        (pc),
    .opA       (opA),
    .opB       (opB),
    .stall     (stall),
    .aluResult (aluResult),
    .regWrite  (regWrite),
    .memWrite  (memWrite),
    .memEn     (memEn),
    .memToReg  (memToReg),
    .writeReg  (writeReg),
    .pcOut     (pcOut),
    .storeData (storeData),
    .exInstr   (exInstr)
  );

  always #5 clk = ~clk;

  function automatic logic [15:0] rType(input logic [4:0] op, input logic [2:0] s,
                                        input logic [2:0] t, input logic [2:0] d);
    return {op, s, t, d, 2'b00};
  endfunction

  function automatic logic [15:0] iType(input logic [4:0] op, input logic [2:0] s,
                                        input logic [2:0] t, input logic [4:0] imm5);
    return {op, s, t, imm5};
  endfunction

  function automatic logic [4:0] randomOp(input int k);
    case (k)
      0:       return OP_ADD;
      1:       return OP_SUB;
      2:       return OP_AND;
      3:       return OP_XOR;
      4:       return OP_ADDI;
      5:       return OP_SUBI;
      6:       return OP_ANDI;
      7:       return OP_LD;
      8:       return OP_ST;
      9:       return OP_NOP;
      // Unassigned opcode that behaves as NOP
      default: return 5'b00110;
    endcase
  endfunction

  function automatic logic readsRs(input logic [15:0] ins);
    case (ins[15:11])
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_SUBI, OP_ANDI, OP_LD, OP_ST: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic readsRt(input logic [15:0] ins);
    case (ins[15:11])
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ST: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Load in ID/EX whose rt is a source of the instruction in decode
  function automatic logic expectStall(input logic [15:0] exIns, input logic [15:0] cur);
    logic [2:0] loadRt;
    loadRt = exIns[7:5];
    if (exIns[15:11] != OP_LD) return 1'b0;
    return (readsRs(cur) && cur[10:8] == loadRt) || (readsRt(cur) && cur[7:5] == loadRt);
  endfunction

  function automatic expectT predictOutputs(input logic [15:0] ins, input logic [15:0] a,
                                            input logic [15:0] b, input logic [15:0] p);
    expectT      e;
    logic [15:0] sext;
    logic [15:0] zext;
    sext = {{11{ins[4]}}, ins[4:0]};
    zext = {11'b0, ins[4:0]};
    e = '0;
    e.instr = ins;
    e.pc = p;
    e.storeData = b;
    e.aluValid = 1'b1;
    case (ins[15:11])
      OP_ADD:       e.aluResult = a + b;
      OP_SUB:       e.aluResult = a - b;
      OP_AND:       e.aluResult = a & b;
      OP_XOR:       e.aluResult = a ^ b;
      OP_ADDI:      e.aluResult = a + sext;
      OP_SUBI:      e.aluResult = a - sext;
      OP_ANDI:      e.aluResult = a & zext;
      // Memory address of a load or store
      OP_LD, OP_ST: e.aluResult = a + sext;
      default:      e.aluValid = 1'b0;
    endcase
    case (ins[15:11])
      OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
        e.regWrite = 1'b1;
        e.writeReg = ins[4:2];
      end
      OP_ADDI, OP_SUBI, OP_ANDI, OP_LD: begin
        e.regWrite = 1'b1;
        e.writeReg = ins[7:5];
      end
      default: ;
    endcase
    e.memEn = (ins[15:11] == OP_LD) || (ins[15:11] == OP_ST);
    e.memToReg = (ins[15:11] == OP_LD);
    e.memWrite = (ins[15:11] == OP_ST);
    return e;
  endfunction

  task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] want);
    assert (got === want) else begin
      errorCount++;
      $display("ERROR %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  // Presents one instruction and holds it until it is accepted
  task automatic sendInstr(input logic [15:0] ins, input logic [15:0] a, input logic [15:0] b);
    logic accepted;
    accepted = 1'b0;
    en = 1'b1;
    instr = ins;
    opA = a;
    opB = b;
    pc = pcNext;
    while (!accepted) begin
      @(negedge clk);
      accepted = !stall;
      @(posedge clk);
      #1;
    end
    pcNext = pcNext + 16'd2;
  endtask

  // Later stage holds the latch while inputs keep changing
  task automatic holdInputs(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      en = 1'b0;
      instr = r[15:0];
      opA = r[31:16];
      opB = r[23:8];
      @(posedge clk);
      #1;
    end
  endtask

  // Expected ID/EX contents follow the same edges as the DUT
  always @(posedge clk) begin
    if (!rstN) begin
      modelOut <= '0;
    end else if (en) begin
      if (expectStall(modelOut.instr, instr)) begin
        modelOut <= '{instr: `NOP_INSTR, default: '0};
      end else begin
        modelOut <= predictOutputs(instr, opA, opB, pc);
      end
    end
  end

  always @(negedge clk) begin
    if (rstN) begin
      checkCount++;
      if (en && stall) stallCount++;
      checkValue("stall", 16'(stall), 16'(expectStall(modelOut.instr, instr)));
      checkValue("regWrite", 16'(regWrite), 16'(modelOut.regWrite));
      checkValue("memWrite", 16'(memWrite), 16'(modelOut.memWrite));
      checkValue("memEn", 16'(memEn), 16'(modelOut.memEn));
      checkValue("memToReg", 16'(memToReg), 16'(modelOut.memToReg));
      checkValue("exInstr", exInstr, modelOut.instr);
      if (modelOut.regWrite) checkValue("writeReg", 16'(writeReg), 16'(modelOut.writeReg));
      if (modelOut.aluValid) begin
        checkValue("aluResult", aluResult, modelOut.aluResult);
        checkValue("pcOut", pcOut, modelOut.pc);
        checkValue("storeData", storeData, modelOut.storeData);
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount == MAX_CYCLES) begin
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    logic [31:0] v;
    int          idx;
    clk = 1'b0;
    rstN = 1'b0;
    en = 1'b0;
    instr = `NOP_INSTR;
    pc = '0;
    opA = '0;
    opB = '0;
    seed = 32'h9ed7fbf1;
    errorCount = 0;
    checkCount = 0;
    stallCount = 0;
    cycleCount = 0;
    pcNext = 16'h0100;
    repeat (10) @(posedge clk);
    #1;
    rstN = 1'b1;
    holdInputs(2);

    sendInstr(rType(OP_ADD, 3'd1, 3'd2, 3'd3), 16'h1234, 16'h0F0F);
    sendInstr(rType(OP_SUB, 3'd2, 3'd3, 3'd4), 16'h0005, 16'h0009);
    sendInstr(rType(OP_AND, 3'd4, 3'd5, 3'd6), 16'hF0F0, 16'h3C3C);
    sendInstr(rType(OP_XOR, 3'd6, 3'd7, 3'd1), 16'hAAAA, 16'h5555);
    sendInstr(iType(OP_ADDI, 3'd1, 3'd2, 5'h1D), 16'h0010, 16'hFFFF);
    sendInstr(iType(OP_SUBI, 3'd3, 3'd4, 5'h05), 16'h0003, 16'h0000);
    sendInstr(iType(OP_ANDI, 3'd5, 3'd6, 5'h1F), 16'hFFFF, 16'h1234);
    sendInstr(iType(OP_LD, 3'd1, 3'd4, 5'h1E), 16'h0100, 16'h0000);
    sendInstr(iType(OP_ST, 3'd2, 3'd5, 5'h04), 16'h0200, 16'hBEEF);
    // Load-use through rs and then through the rt of a store
    sendInstr(iType(OP_LD, 3'd1, 3'd4, 5'h02), 16'h0300, 16'h0000);
    sendInstr(rType(OP_ADD, 3'd4, 3'd2, 3'd6), 16'h0007, 16'h0008);
    sendInstr(iType(OP_LD, 3'd3, 3'd2, 5'h00), 16'h0400, 16'h0000);
    sendInstr(iType(OP_ST, 3'd1, 3'd2, 5'h10), 16'h0500, 16'hCAFE);
    // ADDI reads only rs and must not stall here
    sendInstr(iType(OP_LD, 3'd1, 3'd3, 5'h01), 16'h0600, 16'h0000);
    sendInstr(iType(OP_ADDI, 3'd5, 3'd3, 5'h01), 16'h0020, 16'h0000);
    sendInstr(iType(OP_LD, 3'd2, 3'd7, 5'h03), 16'h0700, 16'h0000);
    holdInputs(3);
    sendInstr(rType(OP_XOR, 3'd7, 3'd1, 3'd5), 16'h00FF, 16'h0F0F);
    sendInstr(`NOP_INSTR, 16'h1111, 16'h2222);

    for (int i = 0; i < RANDOM_COUNT; i++) begin
      r = $random(seed);
      v = $random(seed);
      if (r[2:0] == 3'd0) holdInputs(1 + int'(r[4:3]));
      idx = $unsigned($random(seed)) % 11;
      sendInstr({randomOp(idx), r[26:16]}, v[15:0], v[31:16]);
    end
    holdInputs(2);

    assert (stallCount > 0) else begin
      errorCount++;
      $display("No load-use stall was observed during the run");
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* decodeExecute.f */
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/decodeUnit.sv
logic/hazardUnit.sv
logic/stageLatch.sv
logic/idExLatch.sv
logic/executeUnit.sv
logic/decodeExecute.sv
bench/decodeExecute_asserts.sv
bench/decodeExecute_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decodeExecute.f \
  --top-module decodeExecute_tb -Mdir obj_dir

out=$(./obj_dir/VdecodeExecute_tb)
echo "$out"
echo "$out" | grep -q "^Finished with no errors$"
